/* hw/dram_init_cfg.svh */
`ifndef DRAM_INIT_CFG_SVH
`define DRAM_INIT_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Init timing, in controller clock cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Each of POWER_UP, PRE_RESET and RESET.
`define T_PWUP      20
`define T_XPR       12  // Reset release to first MRS, tPDc folded in.
`define T_DLLK      16  // DLL lock after MR0 with DLL reset.
`define T_MOD       6
`define T_ZQINIT    24

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define TIMER_BITS  12
`define ADDR_BITS   17

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode-register payloads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// A8 is DLL reset.
`define MR0_VAL     17'h00D40
`define MR1_VAL     17'h00101  // DLL enable.
`define MR2_VAL     17'h00018
`define MR3_VAL     17'h00000
`define MR4_VAL     17'h00000
`define MR5_VAL     17'h00400
`define MR6_VAL     17'h00800

`endif

/* hw/dram_pkg.sv */
`include "dram_init_cfg.svh"

package dram_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Init sequence states.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        LOAD_MODE_DLL,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG1,
        LOAD_BG0_REG0,
        ZQ_CL,
        IDLE
    } dram_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DRAM command bus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                   reset_n;
        logic                   cke;
        logic                   cs_n;
        logic                   act_n;
        logic                   ras_n;
        logic                   cas_n;
        logic                   we_n;
        logic [1:0]             bg;
        logic [1:0]             ba;
        logic [`ADDR_BITS-1:0]  addr;
    } dram_cmd_t;

    // Commands used during init.
    typedef enum logic [1:0] {
        DESELECT,
        MRS,
        ZQCL
    } dram_cmd_kind_t;

endpackage

/* hw/time_counter.sv */
`timescale 1ns/100ps

`include "dram_init_cfg.svh"

module time_counter #(
    parameter int NBITS = `TIMER_BITS
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] overflow_val,
    output logic [NBITS-1:0] count_out,
    output logic             overflow_flag
);

    logic [NBITS-1:0] next_count;

    always_comb begin
        next_count = count_out;
        if (clear) begin
            next_count = '0;  // Clear beats count.
        end else if (count_enable) begin
            next_count = count_out + 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count_out <= '0;
        end else begin
            count_out <= next_count;
        end
    end

    assign overflow_flag = (count_out == overflow_val);

    // The owner must clear on the flag, so the count stays in range.
    a_count_in_range: assert property (
        @(posedge CLK) disable iff (!nRST)
        (count_enable && !clear) |-> (count_out <= overflow_val)
    ) else $error("time_counter: count %0h above limit %0h", count_out, overflow_val);

endmodule

/* hw/init_fsm.sv */
`timescale 1ns/100ps

`include "dram_init_cfg.svh"

module init_fsm import dram_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   init,
    input  logic                   timer_flag,
    output logic                   timer_clear,
    output logic                   timer_en,
    output logic [`TIMER_BITS-1:0] timer_limit,
    output dram_state_t            state,
    output logic                   state_entry,
    output logic                   init_valid
);

    localparam logic [`TIMER_BITS-1:0] LIM_PWUP   = `T_PWUP;
    localparam logic [`TIMER_BITS-1:0] LIM_XPR    = `T_XPR;
    localparam logic [`TIMER_BITS-1:0] LIM_DLLK   = `T_DLLK;
    localparam logic [`TIMER_BITS-1:0] LIM_MOD    = `T_MOD;
    localparam logic [`TIMER_BITS-1:0] LIM_ZQINIT = `T_ZQINIT;

    dram_state_t n_state;
    logic        n_timer_en;
    logic        n_init_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and control registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= POWER_UP;
            timer_en    <= 1'b0;
            init_valid  <= 1'b0;
            state_entry <= 1'b0;
        end else begin
            state       <= n_state;
            timer_en    <= n_timer_en;
            init_valid  <= n_init_valid;
            state_entry <= (n_state != state);  // First cycle of the new state.
        end
    end

    // Wait length for each state.
    always_comb begin
        case (state)
            POWER_UP,
            PRE_RESET,
            RESET:         timer_limit = LIM_PWUP;
            NOP:           timer_limit = LIM_XPR;
            LOAD_MODE_DLL: timer_limit = LIM_DLLK;
            LOAD_BG0_REG3,
            LOAD_BG1_REG6,
            LOAD_BG1_REG5,
            LOAD_BG1_REG4,
            LOAD_BG0_REG2,
            LOAD_BG0_REG1,
            LOAD_BG0_REG0: timer_limit = LIM_MOD;
            ZQ_CL:         timer_limit = LIM_ZQINIT;
            default:       timer_limit = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        n_state      = state;
        n_timer_en   = timer_en;
        n_init_valid = init_valid;
        timer_clear  = 1'b0;

        // Timer starts the cycle after init.
        if (state == POWER_UP && init) begin
            n_timer_en = 1'b1;
        end

        if (timer_en && timer_flag) begin
            timer_clear = 1'b1;
            case (state)
                POWER_UP:      n_state = PRE_RESET;
                PRE_RESET:     n_state = RESET;
                RESET:         n_state = NOP;
                NOP:           n_state = LOAD_MODE_DLL;
                LOAD_MODE_DLL: n_state = LOAD_BG0_REG3;
                LOAD_BG0_REG3: n_state = LOAD_BG1_REG6;
                LOAD_BG1_REG6: n_state = LOAD_BG1_REG5;
                LOAD_BG1_REG5: n_state = LOAD_BG1_REG4;
                LOAD_BG1_REG4: n_state = LOAD_BG0_REG2;
                LOAD_BG0_REG2: n_state = LOAD_BG0_REG1;
                LOAD_BG0_REG1: n_state = LOAD_BG0_REG0;
                LOAD_BG0_REG0: n_state = ZQ_CL;
                ZQ_CL: begin
                    n_state      = IDLE;
                    n_init_valid = 1'b1;  // Calibration done.
                    n_timer_en   = 1'b0;
                end
                default:       n_state = state;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_valid_only_idle: assert property (
        @(posedge CLK) disable iff (!nRST)
        init_valid |-> (state == IDLE)
    ) else $error("init_fsm: init_valid high in state %s", state.name());

    a_no_clear_idle: assert property (
        @(posedge CLK) disable iff (!nRST)
        (state == IDLE) |-> !timer_clear
    ) else $error("init_fsm: timer cleared in IDLE");

endmodule

/* hw/cmd_encoder.sv */
`timescale 1ns/100ps

`include "dram_init_cfg.svh"

module cmd_encoder import dram_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  dram_state_t state,
    input  logic        state_entry,
    output dram_cmd_t   cmd
);

    localparam logic [`ADDR_BITS-1:0] ZQ_ADDR = 1 << 10;  // A10 = ZQCL long.

    dram_cmd_kind_t        kind;
    logic [2:0]            mr_sel;
    logic [`ADDR_BITS-1:0] mr_val;
    dram_cmd_t             cmd_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        kind   = MRS;
        mr_sel = 3'd0;
        case (state)
            LOAD_MODE_DLL: mr_sel = 3'd0;
            LOAD_BG0_REG3: mr_sel = 3'd3;
            LOAD_BG1_REG6: mr_sel = 3'd6;
            LOAD_BG1_REG5: mr_sel = 3'd5;
            LOAD_BG1_REG4: mr_sel = 3'd4;
            LOAD_BG0_REG2: mr_sel = 3'd2;
            LOAD_BG0_REG1: mr_sel = 3'd1;
            LOAD_BG0_REG0: mr_sel = 3'd0;
            ZQ_CL:         kind = ZQCL;
            default:       kind = DESELECT;
        endcase
    end

    always_comb begin
        case (mr_sel)
            3'd0:    mr_val = `MR0_VAL;
            3'd1:    mr_val = `MR1_VAL;
            3'd2:    mr_val = `MR2_VAL;
            3'd3:    mr_val = `MR3_VAL;
            3'd4:    mr_val = `MR4_VAL;
            3'd5:    mr_val = `MR5_VAL;
            default: mr_val = `MR6_VAL;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus contents.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cmd_d = '{reset_n: 1'b1, cke: 1'b1, cs_n: 1'b1, act_n: 1'b1, ras_n: 1'b1,
                  cas_n: 1'b1, we_n: 1'b1, bg: 2'd0, ba: 2'd0, addr: '0};

        cmd_d.reset_n = !(state inside {PRE_RESET, RESET});
        cmd_d.cke     = !(state inside {POWER_UP, PRE_RESET, RESET});  // High from NOP on.

        if (state_entry) begin
            case (kind)
                MRS: begin
                    cmd_d.cs_n  = 1'b0;
                    cmd_d.ras_n = 1'b0;
                    cmd_d.cas_n = 1'b0;
                    cmd_d.we_n  = 1'b0;
                    cmd_d.bg    = {1'b0, mr_sel[2]};  // MR4..MR6 sit in BG1.
                    cmd_d.ba    = mr_sel[1:0];
                    cmd_d.addr  = mr_val;
                end
                ZQCL: begin
                    cmd_d.cs_n = 1'b0;
                    cmd_d.we_n = 1'b0;
                    cmd_d.addr = ZQ_ADDR;
                end
                default: cmd_d.cs_n = 1'b1;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cmd <= '{reset_n: 1'b0, cke: 1'b0, cs_n: 1'b1, act_n: 1'b1, ras_n: 1'b1,
                     cas_n: 1'b1, we_n: 1'b1, bg: 2'd0, ba: 2'd0, addr: '0};
        end else begin
            cmd <= cmd_d;
        end
    end

    // Commands only once the clock is enabled.
    a_cmd_needs_cke: assert property (
        @(posedge CLK) disable iff (!nRST)
        !cmd.cs_n |-> cmd.cke
    ) else $error("cmd_encoder: command issued with cke low");

endmodule

/* hw/dram_init_top.sv */
`timescale 1ns/100ps

`include "dram_init_cfg.svh"

module dram_init_top import dram_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        init,
    output dram_cmd_t   cmd,
    output logic        init_valid,
    output dram_state_t init_state
);

    logic                   timer_clear;
    logic                   timer_en;
    logic                   timer_flag;
    logic [`TIMER_BITS-1:0] timer_limit;
    logic                   state_entry;

    time_counter #(.NBITS(`TIMER_BITS)) time_counter0 (
        .CLK           (CLK),
        .nRST          (nRST),
        .clear         (timer_clear),
        .count_enable  (timer_en),
        .overflow_val  (timer_limit),
        .count_out     (),
        .overflow_flag (timer_flag)
    );

    init_fsm init_fsm0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .init        (init),
        .timer_flag  (timer_flag),
        .timer_clear (timer_clear),
        .timer_en    (timer_en),
        .timer_limit (timer_limit),
        .state       (init_state),
        .state_entry (state_entry),
        .init_valid  (init_valid)
    );

    cmd_encoder cmd_encoder0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .state       (init_state),
        .state_entry (state_entry),
        .cmd         (cmd)
    );

endmodule

/* tests/dram_init_tb.sv */
`timescale 1ns/100ps

`include "dram_init_cfg.svh"

module dram_init_tb import dram_pkg::*; ();

    localparam int N_CMDS        = 9;
    localparam int STABLE_CYCLES = 50;
    localparam int ZQ_TO_VALID   = `T_ZQINIT + 1 - 1;  // Encoder register eats one cycle.

    typedef struct packed {
        dram_cmd_kind_t        kind;
        logic [1:0]            bg;
        logic [1:0]            ba;
        logic [`ADDR_BITS-1:0] addr;
        logic [31:0]           gap;   // Cycles since the previous command.
    } cmd_row_t;

    logic        CLK  = 1'b0;
    logic        nRST = 1'b0;
    logic        init = 1'b0;
    dram_cmd_t   cmd;
    logic        init_valid;
    dram_state_t init_state;

    cmd_row_t    exp_tab [N_CMDS];
    int unsigned cycle         = 0;
    int unsigned start_cycle   = 0;
    int unsigned timeout_limit = 0;
    int unsigned checks        = 0;
    int unsigned errors        = 0;
    logic        watch_on      = 1'b0;
    logic        expect_cmds   = 1'b0;
    logic        exp_reset_n   = 1'b0;
    logic        exp_cke       = 1'b0;

    dram_init_top dut0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .init       (init),
        .cmd        (cmd),
        .init_valid (init_valid),
        .init_state (init_state)
    );

    initial begin
        forever #50 CLK = ~CLK;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // act_n, ras_n, cas_n, we_n.
    function automatic logic [3:0] opcode_for(input dram_cmd_kind_t k);
        case (k)
            MRS:     return 4'b1000;
            ZQCL:    return 4'b1110;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic cmd_row_t make_row(input dram_cmd_kind_t k, input logic [1:0] bg,
                                          input logic [1:0] ba,
                                          input logic [`ADDR_BITS-1:0] addr,
                                          input int unsigned gap);
        cmd_row_t r;
        r.kind = k;
        r.bg   = bg;
        r.ba   = ba;
        r.addr = addr;
        r.gap  = gap;
        return r;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR: %s (cycle %0d)", what, cycle);
        end
    endtask

    task automatic build_table();
        logic [`ADDR_BITS-1:0] zq_addr;
        int                    k;
        zq_addr    = {{(`ADDR_BITS-11){1'b0}}, 1'b1, 10'd0};  // A10 set.
        exp_tab[0] = make_row(MRS,  2'd0, 2'd0, `MR0_VAL, 0);
        exp_tab[1] = make_row(MRS,  2'd0, 2'd3, `MR3_VAL, `T_DLLK + 1);
        exp_tab[2] = make_row(MRS,  2'd1, 2'd2, `MR6_VAL, `T_MOD + 1);
        exp_tab[3] = make_row(MRS,  2'd1, 2'd1, `MR5_VAL, `T_MOD + 1);
        exp_tab[4] = make_row(MRS,  2'd1, 2'd0, `MR4_VAL, `T_MOD + 1);
        exp_tab[5] = make_row(MRS,  2'd0, 2'd2, `MR2_VAL, `T_MOD + 1);
        exp_tab[6] = make_row(MRS,  2'd0, 2'd1, `MR1_VAL, `T_MOD + 1);
        exp_tab[7] = make_row(MRS,  2'd0, 2'd0, `MR0_VAL, `T_MOD + 1);
        exp_tab[8] = make_row(ZQCL, 2'd0, 2'd0, zq_addr,  `T_MOD + 1);
        timeout_limit = 3 * `T_PWUP + `T_XPR + 100 + STABLE_CYCLES;
        for (k = 0; k < N_CMDS; k++) begin
            timeout_limit += exp_tab[k].gap;
        end
    endtask

    task automatic check_row(input int idx, input int unsigned prev_cycle);
        cmd_row_t r;
        r = exp_tab[idx];
        check_hex($sformatf("cmd[%0d] act_n/ras_n/cas_n/we_n", idx),
                  32'({cmd.act_n, cmd.ras_n, cmd.cas_n, cmd.we_n}),
                  32'(opcode_for(r.kind)));
        check_hex($sformatf("cmd[%0d].bg", idx), 32'(cmd.bg), 32'(r.bg));
        check_hex($sformatf("cmd[%0d].ba", idx), 32'(cmd.ba), 32'(r.ba));
        check_hex($sformatf("cmd[%0d].addr", idx), 32'(cmd.addr), 32'(r.addr));
        if (idx > 0) begin
            check_hex($sformatf("cmd[%0d] gap", idx), cycle - prev_cycle, r.gap);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitors.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bus levels follow the state one cycle late.
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            exp_reset_n <= 1'b0;
            exp_cke     <= 1'b0;
        end else begin
            exp_reset_n <= !(init_state inside {PRE_RESET, RESET});
            exp_cke     <= exp_cke || (init_state == NOP);  // Sticky once NOP is reached.
        end
    end

    always @(negedge CLK) begin
        check_hex("cmd.reset_n", 32'(cmd.reset_n), 32'(exp_reset_n));
        check_hex("cmd.cke", 32'(cmd.cke), 32'(exp_cke));
        expect_true(expect_cmds || cmd.cs_n, "command on the bus while none was expected");
    end

    always @(posedge CLK) begin
        cycle <= cycle + 1;
        if (watch_on && (cycle - start_cycle > timeout_limit)) begin
            errors++;
            $display("Timeout: run did not finish within %0d cycles of init", timeout_limit);
            $display("%0d checks, %0d errors", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main_flow
        logic [31:0] lfsr;
        logic [3:0]  delay;
        int unsigned last_cycle;
        int unsigned zq_cycle;
        logic        missing;
        int          i;
        int          b;

        lfsr       = 32'h68cc_0b84;
        delay      = 4'd0;
        last_cycle = 0;
        zq_cycle   = 0;
        missing    = 1'b0;
        build_table();

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        check_hex("init_valid", 32'(init_valid), 32'h0);
        check_hex("cmd.cs_n", 32'(cmd.cs_n), 32'h1);
        check_hex("init_state", 32'(init_state), 32'(POWER_UP));
        nRST = 1'b1;

        for (b = 0; b < 4; b++) begin
            delay[b] = lfsr[0];
            lfsr     = lfsr_step(lfsr);
        end
        repeat (delay) begin
            @(negedge CLK);
            check_hex("init_valid", 32'(init_valid), 32'h0);
            check_hex("init_state", 32'(init_state), 32'(POWER_UP));
        end

        @(negedge CLK);
        init        = 1'b1;
        expect_cmds = 1'b1;
        watch_on    = 1'b1;
        start_cycle = cycle;
        @(negedge CLK);
        init = 1'b0;

        for (i = 0; i < N_CMDS && !missing; i++) begin
            @(negedge CLK);
            while (cmd.cs_n && !init_valid) @(negedge CLK);
            if (cmd.cs_n) begin
                missing = 1'b1;
                expect_true(1'b0, $sformatf("command %0d never appeared before init_valid", i));
            end else begin
                check_row(i, last_cycle);
                last_cycle = cycle;
            end
        end
        zq_cycle = last_cycle;

        @(posedge CLK);
        expect_cmds = 1'b0;  // Nothing more after ZQCL.
        @(negedge CLK);
        while (!init_valid) @(negedge CLK);
        if (!missing) begin
            check_hex("init_valid delay", cycle - zq_cycle, 32'(ZQ_TO_VALID));
        end
        check_hex("init_state", 32'(init_state), 32'(IDLE));

        // Second init in IDLE.
        @(negedge CLK);
        init = 1'b1;
        @(negedge CLK);
        init = 1'b0;
        repeat (STABLE_CYCLES) begin
            @(negedge CLK);
            check_hex("init_valid", 32'(init_valid), 32'h1);
            check_hex("init_state", 32'(init_state), 32'(IDLE));
        end
        watch_on = 1'b0;

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* dram_init.f */
+incdir+hw
hw/dram_pkg.sv
hw/time_counter.sv
hw/init_fsm.sv
hw/cmd_encoder.sv
hw/dram_init_top.sv
tests/dram_init_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DRAM init testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module dram_init_tb \
    -Mdir obj_dir -o dram_init_sim \
    -f dram_init.f || { echo "Build failed"; exit 1; }

./obj_dir/dram_init_sim > "$LOG" 2>&1 || echo "Simulator returned a failing status"
cat "$LOG"

grep -qx "ALL CHECKS PASSED" "$LOG" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
